// File: project.f
common/obuf_bias_pkg.sv
tile_reuse/reuse_flag_fifo.sv
tile_reuse/tile_reuse_detector.sv
rtl/bias_addr_history.sv
rtl/bias_sel_ctrl.sv
rtl/obuf_bias_sel_top.sv
sim/obuf_bias_sel_tb.sv

// File: Makefile
TOP := obuf_bias_sel_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf obj_dir

// File: sim/obuf_bias_sel_tb.sv
/*
 * obuf/bias select unit testbench
 * table of per-cycle stimulus with expected select, applied in a loop
 */
module obuf_bias_sel_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import obuf_bias_pkg::*;

  // one table row = DUT inputs for one cycle plus the expected select
  typedef struct packed {
    logic                   compute_done;
    logic                   decoder_done;
    logic                   base_loop_enter;
    tile_cmd_t              tile_cmd;
    obuf_ld_t               obuf_ld;
    logic [bbuf_addr_w-1:0] bias_ld_addr;
    loop_cfg_t              loop_cfg;
    logic                   exp_sel;
    logic                   chk;
  } stim_row_t;

  // load address that never matches the history
  localparam logic [obuf_addr_w-1:0] idle_ld_addr = 8'hff;

  logic                   clk;
  logic                   reset;
  logic                   compute_done;
  logic                   decoder_done;
  logic                   base_loop_enter;
  tile_cmd_t              tile_cmd;
  obuf_ld_t               obuf_ld;
  logic [bbuf_addr_w-1:0] bias_ld_addr;
  loop_cfg_t              loop_cfg;
  logic                   obuf_bias_sel;

  stim_row_t              rows[$];
  logic [bbuf_addr_w-1:0] bias_level;
  int                     errors;
  int                     checks;
  int                     cycle_count;

  obuf_bias_sel_top DUT (
    .clk             (clk),
    .reset           (reset),
    .compute_done    (compute_done),
    .decoder_done    (decoder_done),
    .base_loop_enter (base_loop_enter),
    .tile_cmd        (tile_cmd),
    .obuf_ld         (obuf_ld),
    .bias_ld_addr    (bias_ld_addr),
    .loop_cfg        (loop_cfg),
    .obuf_bias_sel   (obuf_bias_sel)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ====================================================================
  // checking and driving
  // ====================================================================

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0t ns: %s = %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic drive_inputs(input stim_row_t r);
    compute_done    = r.compute_done;
    decoder_done    = r.decoder_done;
    base_loop_enter = r.base_loop_enter;
    tile_cmd        = r.tile_cmd;
    obuf_ld         = r.obuf_ld;
    bias_ld_addr    = r.bias_ld_addr;
    loop_cfg        = r.loop_cfg;
  endtask

  // ====================================================================
  // table building
  // ====================================================================

  // quiet cycle, bias address holds its level
  function automatic stim_row_t blank_row(input logic exp_sel);
    stim_row_t r;
    r              = '0;
    r.obuf_ld.addr = idle_ld_addr;
    r.bias_ld_addr = bias_level;
    r.exp_sel      = exp_sel;
    r.chk          = 1'b1;
    return r;
  endfunction

  task automatic idle_cycles(input int n, input logic exp_sel, input logic chk);
    stim_row_t r;
    r     = blank_row(exp_sel);
    r.chk = chk;
    repeat (n) rows.push_back(r);
  endtask

  task automatic config_strobe(input logic [loop_id_w-1:0] id, input logic exp_sel);
    stim_row_t r;
    r                  = blank_row(exp_sel);
    r.loop_cfg.valid   = 1'b1;
    r.loop_cfg.loop_id = id;
    rows.push_back(r);
  endtask

  task automatic tile_base(input logic [tile_addr_w-1:0] base, input logic exp_sel);
    stim_row_t r;
    r                = blank_row(exp_sel);
    r.tile_cmd.valid = 1'b1;
    r.tile_cmd.base  = base;
    rows.push_back(r);
  endtask

  task automatic compute_pulse(input logic exp_sel);
    stim_row_t r;
    r              = blank_row(exp_sel);
    r.compute_done = 1'b1;
    rows.push_back(r);
  endtask

  task automatic decoder_pulse(input logic exp_sel);
    stim_row_t r;
    r              = blank_row(exp_sel);
    r.decoder_done = 1'b1;
    rows.push_back(r);
  endtask

  task automatic obuf_load(input logic [obuf_addr_w-1:0] addr, input logic exp_sel);
    stim_row_t r;
    r               = blank_row(exp_sel);
    r.obuf_ld.valid = 1'b1;
    r.obuf_ld.addr  = addr;
    rows.push_back(r);
  endtask

  // new bias level from this cycle on, optional base loop entry
  task automatic bias_enter(input logic [bbuf_addr_w-1:0] addr, input logic enter,
                            input logic exp_sel);
    stim_row_t r;
    bias_level        = addr;
    r                 = blank_row(exp_sel);
    r.base_loop_enter = enter;
    rows.push_back(r);
  endtask

  // expected select is the output after the edge that samples the row
  task automatic build_table();
    // first layer, conditions that would select obuf are masked
    idle_cycles(1, 1'b0, 1'b0);
    config_strobe(5'd0, 1'b0);
    obuf_load(8'd20, 1'b0);
    tile_base(42'h100, 1'b0);
    tile_base(42'h100, 1'b0);
    compute_pulse(1'b0);
    idle_cycles(2, 1'b0, 1'b1);
    // second layer, select register visible
    config_strobe(5'd0, 1'b0);
    idle_cycles(1, 1'b0, 1'b1);
    // equal bases, flag 1, output two cycles after compute_done
    tile_base(42'h2_0000_0040, 1'b0);
    tile_base(42'h2_0000_0040, 1'b0);
    compute_pulse(1'b0);
    idle_cycles(2, 1'b1, 1'b1);
    // different base, flag 0 gives end of block
    tile_base(42'h1234_5678, 1'b1);
    compute_pulse(1'b1);
    idle_cycles(2, 1'b0, 1'b1);
    // reuse again, then compute_done on an empty FIFO
    tile_base(42'h1234_5678, 1'b0);
    compute_pulse(1'b0);
    idle_cycles(1, 1'b1, 1'b1);
    compute_pulse(1'b1);
    idle_cycles(2, 1'b0, 1'b1);
    // record bias address 0, first matching load swallowed
    bias_enter(8'd0, 1'b1, 1'b0);
    idle_cycles(1, 1'b0, 1'b1);
    idle_cycles(1, 1'b0, 1'b1);
    obuf_load(8'd0, 1'b0);
    idle_cycles(1, 1'b0, 1'b1);
    obuf_load(8'd0, 1'b1);
    idle_cycles(1, 1'b1, 1'b1);
    // loop config clears select and history, entry 0 back to 20
    config_strobe(5'd2, 1'b0);
    obuf_load(8'd0, 1'b0);
    idle_cycles(1, 1'b0, 1'b1);
    obuf_load(8'd20, 1'b1);
    idle_cycles(1, 1'b1, 1'b1);
    // decoder_done restarts the layer count
    decoder_pulse(1'b1);
    config_strobe(5'd0, 1'b0);
    obuf_load(8'd20, 1'b0);
    idle_cycles(2, 1'b0, 1'b1);
  endtask

  // ====================================================================
  // main sequence
  // ====================================================================

  initial begin
    int idx;
    errors     = 0;
    checks     = 0;
    bias_level = 8'h33;
    reset      = 1'b1;
    drive_inputs(blank_row(1'b0));
    build_table();
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;
    for (idx = 0; idx < rows.size(); idx++) begin
      drive_inputs(rows[idx]);
      @(posedge clk);
      #1;
      if (rows[idx].chk) begin
        check_value($sformatf("obuf_bias_sel row %0d", idx), obuf_bias_sel,
                    rows[idx].exp_sel);
      end
    end
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog, table length plus margin
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > rows.size() + 50) begin
      $display("timeout: stimulus table did not finish within %0d cycles", cycle_count);
      $display("RESULT: FAIL");
      $finish;
    end
  end

endmodule

// File: rtl/obuf_bias_sel_top.sv
/*
 * obuf/bias select unit, top level
 * picks the accumulator start source for each output tile
 */
module obuf_bias_sel_top (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  compute_done,
  input  logic                                  decoder_done,
  input  logic                                  base_loop_enter,
  input  obuf_bias_pkg::tile_cmd_t              tile_cmd,
  input  obuf_bias_pkg::obuf_ld_t               obuf_ld,
  input  logic [obuf_bias_pkg::bbuf_addr_w-1:0] bias_ld_addr,
  input  obuf_bias_pkg::loop_cfg_t              loop_cfg,
  output logic                                  obuf_bias_sel
);

  // detector to control
  logic flag_valid;
  logic flag;

  // control to history
  logic end_of_block;

  // history to control
  logic record;
  logic addr_hit;

  // reuse flags, one per compute_done
  tile_reuse_detector u_tile_reuse (
    .clk          (clk),
    .reset        (reset),
    .compute_done (compute_done),
    .decoder_done (decoder_done),
    .tile_cmd     (tile_cmd),
    .loop_cfg     (loop_cfg),
    .flag_valid   (flag_valid),
    .flag         (flag)
  );

  bias_addr_history u_bias_hist (
    .clk             (clk),
    .reset           (reset),
    .decoder_done    (decoder_done),
    .base_loop_enter (base_loop_enter),
    .end_of_block    (end_of_block),
    .bias_ld_addr    (bias_ld_addr),
    .obuf_ld         (obuf_ld),
    .loop_cfg        (loop_cfg),
    .record          (record),
    .addr_hit        (addr_hit)
  );

  bias_sel_ctrl u_sel_ctrl (
    .clk           (clk),
    .reset         (reset),
    .flag_valid    (flag_valid),
    .flag          (flag),
    .record        (record),
    .addr_hit      (addr_hit),
    .decoder_done  (decoder_done),
    .loop_cfg      (loop_cfg),
    .end_of_block  (end_of_block),
    .obuf_bias_sel (obuf_bias_sel)
  );

endmodule

// File: rtl/bias_sel_ctrl.sv
/*
 * bias select control
 * layer counter, end of block and the registered obuf/bias select
 */
module bias_sel_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     flag_valid,
  input  logic                     flag,
  input  logic                     record,
  input  logic                     addr_hit,
  input  logic                     decoder_done,
  input  obuf_bias_pkg::loop_cfg_t loop_cfg,
  output logic                     end_of_block,
  output logic                     obuf_bias_sel
);

  import obuf_bias_pkg::*;

  logic [layer_cnt_w-1:0] layer_cnt;
  logic                   sel_q;
  logic                   layer_strobe;

  // ==================================================================
  // end of block
  // ==================================================================

  // popped flag 0 or nothing queued at compute_done
  assign end_of_block = flag_valid && !flag;

  // ==================================================================
  // select register
  // ==================================================================

  // 1 = start from obuf partial sums, 0 = start from bias
  always_ff @(posedge clk) begin
    if (reset) begin
      sel_q <= 1'b0;
    end else if (end_of_block || loop_cfg.valid || record) begin
      sel_q <= 1'b0;
    end else if (flag_valid) begin
      sel_q <= flag;
    end else if (addr_hit) begin
      sel_q <= 1'b1;
    end
  end

  // ==================================================================
  // layer counter
  // ==================================================================

  // loop id 0 marks the outermost loop of a new layer
  assign layer_strobe = loop_cfg.valid && (loop_cfg.loop_id == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      layer_cnt <= '0;
    end else if (decoder_done) begin
      layer_cnt <= '0;
    end else if (layer_strobe) begin
      layer_cnt <= layer_cnt + 1'b1;
    end
  end

  // first layer has no partial sums to resume from
  assign obuf_bias_sel = (layer_cnt == bias_layer) ? 1'b0 : sel_q;

endmodule

// File: rtl/bias_addr_history.sv
/*
 * bias address history
 * records bias load addresses per fresh round and flags obuf load hits
 */
module bias_addr_history (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  decoder_done,
  input  logic                                  base_loop_enter,
  input  logic                                  end_of_block,
  input  logic [obuf_bias_pkg::bbuf_addr_w-1:0] bias_ld_addr,
  input  obuf_bias_pkg::obuf_ld_t               obuf_ld,
  input  obuf_bias_pkg::loop_cfg_t              loop_cfg,
  output logic                                  record,
  output logic                                  addr_hit
);

  import obuf_bias_pkg::*;

  logic [bbuf_addr_w-1:0] hist [hist_depth];
  logic [bbuf_addr_w-1:0] prev_bias_addr;
  logic [hist_ptr_w-1:0]  write_ptr;
  logic [hist_ptr_w-1:0]  latest_ptr;
  logic                   base_loop_enter_q;
  logic                   fresh_round;
  logic                   skip_once;
  logic                   new_bias_addr;
  logic                   hist_clear;
  logic                   ld_match;

  // ==================================================================
  // round tracking
  // ==================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      base_loop_enter_q <= 1'b0;
    end else begin
      base_loop_enter_q <= base_loop_enter;
    end
  end

  // bias address sampled every cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      prev_bias_addr <= '0;
    end else if (decoder_done || loop_cfg.valid) begin
      prev_bias_addr <= '0;
    end else begin
      prev_bias_addr <= bias_ld_addr;
    end
  end

  assign new_bias_addr = (prev_bias_addr != bias_ld_addr);
  assign hist_clear    = end_of_block || loop_cfg.valid;

  // a round stays fresh until its first address is recorded
  always_ff @(posedge clk) begin
    if (reset) begin
      fresh_round <= 1'b0;
    end else if (hist_clear || new_bias_addr) begin
      fresh_round <= 1'b1;
    end else if (record) begin
      fresh_round <= 1'b0;
    end
  end

  // pointer widened to the bias address for the compare
  assign record = fresh_round && base_loop_enter_q &&
                  ({{(bbuf_addr_w - hist_ptr_w){1'b0}}, write_ptr} == bias_ld_addr);

  // ==================================================================
  // history table
  // ==================================================================

  always_ff @(posedge clk) begin
    if (reset || hist_clear) begin
      write_ptr <= '0;
    end else if (record) begin
      write_ptr <= write_ptr + 1'b1;
    end
  end

  // only entry 0 carries a reset value
  always_ff @(posedge clk) begin
    if (reset || hist_clear) begin
      hist[0] <= hist_empty_mark;
    end else if (record) begin
      hist[write_ptr] <= bias_ld_addr;
    end
  end

  // entry written last, entry 0 before anything was recorded
  assign latest_ptr = (write_ptr == '0) ? '0 : write_ptr - 1'b1;

  // ==================================================================
  // obuf load hit
  // ==================================================================

  assign ld_match = (obuf_ld.addr == hist[0]) || (obuf_ld.addr == hist[latest_ptr]);

  // first matching load after a record is swallowed
  always_ff @(posedge clk) begin
    if (reset) begin
      skip_once <= 1'b0;
    end else if (obuf_ld.valid && ld_match) begin
      skip_once <= 1'b0;
    end else if (record) begin
      skip_once <= 1'b1;
    end
  end

  assign addr_hit = ld_match && !skip_once;

  // past 31 records the pointer would overwrite entry 0
  a_ptr_no_wrap : assert property (@(posedge clk) disable iff (reset)
    record |-> (write_ptr != hist_ptr_w'(hist_depth - 1)));

endmodule

// File: tile_reuse/tile_reuse_detector.sv
/*
 * tile reuse detector
 * compares each tile base with the last one and hands a flag per compute_done
 */
module tile_reuse_detector (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    compute_done,
  input  logic                    decoder_done,
  input  obuf_bias_pkg::tile_cmd_t tile_cmd,
  input  obuf_bias_pkg::loop_cfg_t loop_cfg,
  output logic                    flag_valid,
  output logic                    flag
);

  import obuf_bias_pkg::*;

  logic [tile_addr_w-1:0] last_base;
  logic                   push;
  logic                   push_data;
  logic                   pop;
  logic                   pop_data;
  logic                   empty;
  logic                   popped_q;

  // ==================================================================
  // last tile base
  // ==================================================================

  // zero means no previous tile in this layer
  always_ff @(posedge clk) begin
    if (reset) begin
      last_base <= '0;
    end else if (decoder_done || loop_cfg.valid) begin
      last_base <= '0;
    end else if (tile_cmd.valid) begin
      last_base <= tile_cmd.base;
    end
  end

  // same base as before -> partial sums already sit in obuf
  assign push      = tile_cmd.valid && (last_base != '0);
  assign push_data = (tile_cmd.base == last_base);

  // one flag per compute_done, only when one is queued
  assign pop = compute_done && !empty;

  reuse_flag_fifo #(
    .depth (flag_fifo_depth)
  ) u_flag_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .empty     (empty),
    // overflow is reported inside the queue
    .full      ()
  );

  // ==================================================================
  // flag presentation, one cycle after compute_done
  // ==================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      flag_valid <= 1'b0;
      popped_q   <= 1'b0;
    end else begin
      flag_valid <= compute_done;
      popped_q   <= pop;
    end
  end

  // empty at compute_done reads as 0
  assign flag = popped_q & pop_data;

endmodule

// File: tile_reuse/reuse_flag_fifo.sv
/*
 * reuse flag FIFO
 * small circular queue of one-bit tile reuse flags, registered read data
 */
module reuse_flag_fifo #(
  parameter int depth = obuf_bias_pkg::flag_fifo_depth
) (
  input  logic clk,
  input  logic reset,
  input  logic push,
  input  logic push_data,
  input  logic pop,
  output logic pop_data,
  output logic empty,
  output logic full
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  logic             mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_push;
  logic             do_pop;

  // a push into a full queue is lost
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign empty = (count == '0);
  assign full  = (count == cnt_w'(depth));

  // pointers wrap at depth, so depth need not be a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leave the count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // storage and read register
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
    if (do_pop) begin
      pop_data <= mem[rd_ptr];
    end
  end

  // a lost flag means the accumulator starts a tile from the wrong source
  a_no_push_when_full : assert property (@(posedge clk) disable iff (reset)
    push |-> !full);

  a_no_pop_when_empty : assert property (@(posedge clk) disable iff (reset)
    pop |-> !empty);

endmodule

// File: common/obuf_bias_pkg.sv
/*
 * obuf/bias select unit shared package
 * widths, reset constants and the input groups of the accumulator path
 */
package obuf_bias_pkg;

  // ==================================================================
  // address and id widths
  // ==================================================================

  // output tile base address from the tile command
  localparam int tile_addr_w = 42;

  // output buffer load address
  localparam int obuf_addr_w = 8;

  // bias buffer load address
  localparam int bbuf_addr_w = 8;

  // loop identifier in the loop configuration strobe
  localparam int loop_id_w = 5;

  // ==================================================================
  // history table and counters
  // ==================================================================

  // bias address history entries, one per recorded round
  localparam int hist_depth = 32;
  localparam int hist_ptr_w = 5;

  // layer counter, bumped by loop id 0 strobes
  localparam int layer_cnt_w = 8;

  // reuse flags in flight between tile command and compute_done
  localparam int flag_fifo_depth = 4;

  // ==================================================================
  // reset constants
  // ==================================================================

  // entry 0 after reset or clear, never a real first bias load
  localparam logic [bbuf_addr_w-1:0] hist_empty_mark = 8'd20;

  // first layer always starts from bias
  localparam logic [layer_cnt_w-1:0] bias_layer = 8'd1;

  // ==================================================================
  // input groups
  // ==================================================================

  typedef struct packed {
    logic                   valid;
    logic [tile_addr_w-1:0] base;
  } tile_cmd_t;

  typedef struct packed {
    logic                   valid;
    logic [obuf_addr_w-1:0] addr;
  } obuf_ld_t;

  typedef struct packed {
    logic                 valid;
    logic [loop_id_w-1:0] loop_id;
  } loop_cfg_t;

endpackage
